// ==== include/bscan_settings.svh ====
// boundary-scan opcodes, ir width and reset values, included by the package, rtl and testbench
`ifndef BSCAN_SETTINGS_SVH
`define BSCAN_SETTINGS_SVH

// width of the tap instruction register
`define BSCAN_IR_WIDTH 8

// fixed opcodes of the kept boundary-scan instructions
`define BSCAN_OP_SAMPLE_PRELOAD 8'h01
`define BSCAN_OP_HIGHZ          8'h08
`define BSCAN_OP_EXTEST         8'h09
`define BSCAN_OP_CLAMP          8'h0C
`define BSCAN_OP_EXTEST_TOGGLE  8'h0D

// idle level of the extest_toggle waveform (active-low output)
`define BSCAN_EXTOGSIG_RESET 1'b1

`endif

// ==== hw/bscan_pkg.sv ====
// shared opcode enum and packed control structs, imported by every bscan module and the testbench
`include "bscan_settings.svh"

package bscan_pkg;

   // ********************************************************
   // instruction opcodes
   // ********************************************************
   typedef enum logic [`BSCAN_IR_WIDTH-1:0]
   {
      op_sample_preload = `BSCAN_OP_SAMPLE_PRELOAD,
      op_highz          = `BSCAN_OP_HIGHZ,
      op_extest         = `BSCAN_OP_EXTEST,
      op_clamp          = `BSCAN_OP_CLAMP,
      op_extest_toggle  = `BSCAN_OP_EXTEST_TOGGLE
   } bscan_opcode_e;

   // ********************************************************
   // grouped signals
   // ********************************************************
   // tap fsm state flags, shift_ir_neg already retimed on tck fall
   typedef struct packed
   {
      logic tlrs;
      logic rti;
      logic capture_dr;
      logic shift_dr;
      logic update_dr;
      logic update_ir;
      logic shift_ir_neg;
   } tap_state_t;

   // one-hot style flag per decoded instruction
   typedef struct packed
   {
      logic sampre;
      logic extest;
      logic extog;
      logic highz;
      logic clamp;
   } bscan_instr_t;

   // controls toward the boundary-scan cells
   typedef struct packed
   {
      logic chainen;
      logic mode;
      logic highz;
      logic extogen;
      logic extogsig_b;
   } bscan_pin_t;

   // register strobes for the boundary-scan chain
   typedef struct packed
   {
      logic capturedr;
      logic shiftdr;
      logic updatedr;
      logic updatedr_clk;
   } bscan_dr_t;

endpackage

// ==== hw/bscan_instr_decode.sv ====
// decodes the current and the about-to-load instruction into flag structs for the bscan blocks
`timescale 1ns/100ps

module bscan_instr_decode
(
   input  bscan_pkg::bscan_opcode_e i_ireg,
   input  bscan_pkg::bscan_opcode_e i_ir_shift,
   input  logic                     i_update_ir,
   output bscan_pkg::bscan_instr_t  o_cur_instr,
   output bscan_pkg::bscan_instr_t  o_early_instr
);

   import bscan_pkg::*;

   // decoded ireg
   bscan_instr_t cur_instr;
   // shift stage match, only valid while in update-ir
   bscan_instr_t shift_qual;

   // maps one opcode onto its instruction flag
   // unknown opcodes give no flag at all
   function automatic bscan_instr_t decode_op(input bscan_opcode_e op);
      bscan_instr_t flags;
      flags = '0;
      case (op)
         op_sample_preload: flags.sampre = 1'b1;
         op_extest:         flags.extest = 1'b1;
         op_extest_toggle:  flags.extog  = 1'b1;
         op_highz:          flags.highz  = 1'b1;
         op_clamp:          flags.clamp  = 1'b1;
         default:           flags        = '0;
      endcase
      return flags;
   endfunction

   // ********************************************************
   // current and early instruction flags
   // ********************************************************
   assign cur_instr = decode_op(i_ireg);

   // during update-ir the shift stage already holds the next opcode
   // so the early flags arm one stage before ireg changes
   assign shift_qual = i_update_ir ? decode_op(i_ir_shift) : '0;

   assign o_cur_instr   = cur_instr;
   assign o_early_instr = cur_instr | shift_qual;

endmodule

// ==== hw/bscan_pin_ctrl.sv ====
// deglitched mode, chain, high-z and toggle controls plus the extest_toggle waveform for bscan cells
`timescale 1ns/100ps
`include "bscan_settings.svh"

module bscan_pin_ctrl
(
   input  logic                    atappris_tck,
   input  logic                    powergoodrst_trst_b,
   input  bscan_pkg::tap_state_t   i_tap_state,
   input  bscan_pkg::bscan_instr_t i_cur_instr,
   input  bscan_pkg::bscan_instr_t i_early_instr,
   output bscan_pkg::bscan_pin_t   o_pin
);

   // classes from the current instruction
   logic chain_cur;
   logic mode_cur;
   // classes from the early instruction
   logic chain_early;
   logic mode_early;
   // early classes sampled on tck fall
   logic chain_early_q;
   logic mode_early_q;
   logic highz_early_q;
   logic extogen_early_q;
   // divide-by-two state behind extogsig_b
   logic by_two_q;

   // ********************************************************
   // instruction classes
   // ********************************************************
   // chain covers every kept instruction
   assign chain_cur   = i_cur_instr.sampre | i_cur_instr.extest | i_cur_instr.extog |
                        i_cur_instr.highz  | i_cur_instr.clamp;
   assign chain_early = i_early_instr.sampre | i_early_instr.extest | i_early_instr.extog |
                        i_early_instr.highz  | i_early_instr.clamp;

   // mode means the cells own the pins, sample_preload stays out
   assign mode_cur   = i_cur_instr.extest | i_cur_instr.extog | i_cur_instr.highz |
                       i_cur_instr.clamp;
   assign mode_early = i_early_instr.extest | i_early_instr.extog | i_early_instr.highz |
                       i_early_instr.clamp;

   // early classes move on the falling edge, away from the ireg update on the rise
   always_ff @(negedge atappris_tck or negedge powergoodrst_trst_b)
   begin
      if (!powergoodrst_trst_b)
      begin
         chain_early_q   <= 1'b0;
         mode_early_q    <= 1'b0;
         highz_early_q   <= 1'b0;
         extogen_early_q <= 1'b0;
      end
      else
      begin
         chain_early_q   <= chain_early;
         mode_early_q    <= mode_early;
         highz_early_q   <= i_early_instr.highz;
         extogen_early_q <= i_early_instr.extog;
      end
   end

   // ********************************************************
   // extest_toggle waveform
   // ********************************************************
   // toggles every tck fall while extest_toggle sits in rti
   always_ff @(negedge atappris_tck or negedge powergoodrst_trst_b)
   begin
      if (!powergoodrst_trst_b)
      begin
         by_two_q <= ~`BSCAN_EXTOGSIG_RESET;
      end
      else if (i_tap_state.tlrs)
      begin
         by_two_q <= ~`BSCAN_EXTOGSIG_RESET;
      end
      else
      begin
         by_two_q <= ~by_two_q & i_cur_instr.extog & i_tap_state.rti;
      end
   end

   // a control drops with the current class at once
   // and rises only after the early copy has passed a falling edge
   assign o_pin = '{chainen:    chain_cur & chain_early_q,
                    mode:       mode_cur & mode_early_q,
                    highz:      i_cur_instr.highz & highz_early_q,
                    extogen:    i_cur_instr.extog & extogen_early_q,
                    extogsig_b: ~by_two_q};

endmodule

// ==== hw/bscan_dr_ctrl.sv ====
// gates the tap dr strobes for the boundary-scan chain and builds the falling-edge update clock
`timescale 1ns/100ps

module bscan_dr_ctrl
(
   input  logic                    atappris_tck,
   input  logic                    powergoodrst_trst_b,
   input  bscan_pkg::tap_state_t   i_tap_state,
   input  bscan_pkg::bscan_instr_t i_cur_instr,
   output bscan_pkg::bscan_dr_t    o_dr
);

   // chain is clocked only by scan-chain instructions
   logic scan_en;
   logic updatedr_gated;
   // update strobe one tck fall later
   logic updatedr_clk_q;

   // highz and clamp hold the chain still
   assign scan_en = i_cur_instr.sampre | i_cur_instr.extest | i_cur_instr.extog;

   assign updatedr_gated = i_tap_state.update_dr & scan_en;

   // ********************************************************
   // parallel stage update clock
   // ********************************************************
   // cells with a falling-edge update stage use this copy
   always_ff @(negedge atappris_tck or negedge powergoodrst_trst_b)
   begin
      if (!powergoodrst_trst_b)
      begin
         updatedr_clk_q <= 1'b0;
      end
      else
      begin
         updatedr_clk_q <= updatedr_gated;
      end
   end

   // capture, shift and update follow the tap flags combinationally
   assign o_dr = '{capturedr:    i_tap_state.capture_dr & scan_en,
                   shiftdr:      i_tap_state.shift_dr & scan_en,
                   updatedr:     updatedr_gated,
                   updatedr_clk: updatedr_clk_q};

endmodule

// ==== hw/bscan_tdo_select.sv ====
// retimes the boundary-scan serial output and picks the final tdo between chain and tap
`timescale 1ns/100ps

module bscan_tdo_select
(
   input  logic                    atappris_tck,
   input  logic                    powergoodrst_trst_b,
   input  bscan_pkg::tap_state_t   i_tap_state,
   input  bscan_pkg::bscan_instr_t i_cur_instr,
   input  logic                    i_bscan_tdo,
   input  logic                    i_pre_tdo,
   output logic                    o_tdo
);

   // chain output held on tck fall
   logic bscan_tdo_q;
   // chain drives tdo
   logic select_chain;

   // tdo must change on the falling edge, so the chain bit is retimed here
   always_ff @(negedge atappris_tck or negedge powergoodrst_trst_b)
   begin
      if (!powergoodrst_trst_b)
      begin
         bscan_tdo_q <= 1'b0;
      end
      else if (i_tap_state.tlrs)
      begin
         bscan_tdo_q <= 1'b0;
      end
      else
      begin
         bscan_tdo_q <= i_bscan_tdo;
      end
   end

   // ir shifting always owns tdo, even under a scan-chain instruction
   assign select_chain = (i_cur_instr.sampre | i_cur_instr.extest | i_cur_instr.extog) &
                         ~i_tap_state.shift_ir_neg;

   assign o_tdo = select_chain ? bscan_tdo_q : i_pre_tdo;

endmodule

// ==== hw/bscan_top.sv ====
// boundary-scan control top level joining decode, pin control, dr control and tdo select
`timescale 1ns/100ps

module bscan_top
(
   input  logic                     atappris_tck,
   input  logic                     powergoodrst_trst_b,
   // tap fsm flags and instruction register stages
   input  bscan_pkg::tap_state_t    i_tap_state,
   input  bscan_pkg::bscan_opcode_e i_ireg,
   input  bscan_pkg::bscan_opcode_e i_ir_shift,
   // serial data
   input  logic                     i_bscan_tdo,
   input  logic                     i_pre_tdo,
   // boundary-scan cell controls
   output bscan_pkg::bscan_pin_t    o_pin,
   output bscan_pkg::bscan_dr_t     o_dr,
   output logic                     o_tdo
);

   import bscan_pkg::*;

   // decoded instruction flags
   bscan_instr_t cur_instr;
   bscan_instr_t early_instr;

   // ********************************************************
   // instruction decode
   // ********************************************************
   bscan_instr_decode instr_decode_inst
   (
      .i_ireg        (i_ireg),
      .i_ir_shift    (i_ir_shift),
      .i_update_ir   (i_tap_state.update_ir),
      .o_cur_instr   (cur_instr),
      .o_early_instr (early_instr)
   );

   // ********************************************************
   // cell controls
   // ********************************************************
   bscan_pin_ctrl pin_ctrl_inst
   (
      .atappris_tck        (atappris_tck),
      .powergoodrst_trst_b (powergoodrst_trst_b),
      .i_tap_state         (i_tap_state),
      .i_cur_instr         (cur_instr),
      .i_early_instr       (early_instr),
      .o_pin               (o_pin)
   );

   // chain strobes only follow the current instruction
   bscan_dr_ctrl dr_ctrl_inst
   (
      .atappris_tck        (atappris_tck),
      .powergoodrst_trst_b (powergoodrst_trst_b),
      .i_tap_state         (i_tap_state),
      .i_cur_instr         (cur_instr),
      .o_dr                (o_dr)
   );

   // final tdo mux
   bscan_tdo_select tdo_select_inst
   (
      .atappris_tck        (atappris_tck),
      .powergoodrst_trst_b (powergoodrst_trst_b),
      .i_tap_state         (i_tap_state),
      .i_cur_instr         (cur_instr),
      .i_bscan_tdo         (i_bscan_tdo),
      .i_pre_tdo           (i_pre_tdo),
      .o_tdo               (o_tdo)
   );

endmodule

// ==== tests/bscan_tb_clock.sv ====
// tck and power-good reset source for the bscan testbench, instanced once by the testbench top
`timescale 1ns/100ps

module bscan_tb_clock
(
   output logic atappris_tck,
   output logic powergoodrst_trst_b
);

   // 8 ns period, first rise at 4 ns
   initial
   begin
      atappris_tck = 1'b0;
      forever #4 atappris_tck = ~atappris_tck;
   end

   // reset low for 3 rising edges, released between edges
   initial
   begin
      powergoodrst_trst_b = 1'b0;
      repeat (3) @(posedge atappris_tck);
      #2 powergoodrst_trst_b = 1'b1;
   end

endmodule

// ==== tests/bscan_properties.sv ====
// concurrent checks on the boundary-scan cell controls and chain strobes, bound into the top level
`timescale 1ns/100ps

module bscan_properties
(
   input logic                    atappris_tck,
   input logic                    powergoodrst_trst_b,
   input bscan_pkg::bscan_pin_t   i_pin,
   input bscan_pkg::bscan_dr_t    i_dr,
   input bscan_pkg::bscan_instr_t i_cur_instr
);

   // ********************************************************
   // control ladder
   // ********************************************************
   // cells only own the pins while the chain is enabled
   assert property (@(posedge atappris_tck) disable iff (!powergoodrst_trst_b)
                    i_pin.mode |-> i_pin.chainen)
      else $error("mode set while chainen is low");

   // tristate and toggle both imply pin ownership
   assert property (@(posedge atappris_tck) disable iff (!powergoodrst_trst_b)
                    i_pin.highz |-> i_pin.mode)
      else $error("highz set while mode is low");

   assert property (@(posedge atappris_tck) disable iff (!powergoodrst_trst_b)
                    i_pin.extogen |-> i_pin.mode)
      else $error("extogen set while mode is low");

   // highz and clamp keep the chain unclocked
   assert property (@(posedge atappris_tck) disable iff (!powergoodrst_trst_b)
                    (i_cur_instr.highz | i_cur_instr.clamp) |-> (i_dr == '0))
      else $error("dr strobe active under highz or clamp");

endmodule

bind bscan_top bscan_properties properties_inst
(
   .atappris_tck        (atappris_tck),
   .powergoodrst_trst_b (powergoodrst_trst_b),
   .i_pin               (o_pin),
   .i_dr                (o_dr),
   .i_cur_instr         (cur_instr)
);

// ==== tests/bscan_tb.sv ====
// random-stimulus testbench for the bscan control top, checks each tck rise against a model
`timescale 1ns/100ps
`include "bscan_settings.svh"

module bscan_tb;

   import bscan_pkg::*;

   localparam int NUM_TESTS   = 7;
   localparam int TEST_CYCLES = 150;

   logic          atappris_tck;
   logic          powergoodrst_trst_b;
   // driven copies of the dut inputs
   tap_state_t    tap_drv;
   bscan_opcode_e ireg_drv;
   bscan_opcode_e ir_shift_drv;
   logic          bscan_tdo_drv;
   logic          pre_tdo_drv;
   bscan_pin_t    o_pin;
   bscan_dr_t     o_dr;
   logic          o_tdo;
   // model of the falling-edge flops
   // early_q holds chain, mode, highz and extogen
   logic [3:0]    early_q;
   logic          tog_q;
   logic          upd_clk_q;
   logic          tdo_q;
   logic [4:0]    cur_cls;
   logic [4:0]    shf_cls;
   int            hold_cnt;
   int            test_errs;
   int            err_cnt;
   int            pass_cnt;

   bscan_tb_clock clock_inst
   (
      .atappris_tck        (atappris_tck),
      .powergoodrst_trst_b (powergoodrst_trst_b)
   );

   bscan_top bscan_top_inst
   (
      .atappris_tck        (atappris_tck),
      .powergoodrst_trst_b (powergoodrst_trst_b),
      .i_tap_state         (tap_drv),
      .i_ireg              (ireg_drv),
      .i_ir_shift          (ir_shift_drv),
      .i_bscan_tdo         (bscan_tdo_drv),
      .i_pre_tdo           (pre_tdo_drv),
      .o_pin               (o_pin),
      .o_dr                (o_dr),
      .o_tdo               (o_tdo)
   );

   // class table per opcode as {chain, mode, highz, extogen, scan}
   function automatic logic [4:0] op_class(input logic [7:0] op);
      case (op)
         `BSCAN_OP_SAMPLE_PRELOAD: return 5'b10001;
         `BSCAN_OP_EXTEST:         return 5'b11001;
         `BSCAN_OP_EXTEST_TOGGLE:  return 5'b11011;
         `BSCAN_OP_HIGHZ:          return 5'b11100;
         `BSCAN_OP_CLAMP:          return 5'b11000;
         default:                  return 5'b00000;
      endcase
   endfunction

   // five kept opcodes plus one unknown value
   function automatic bscan_opcode_e random_op(input logic [7:0] r);
      case (r % 8'd6)
         8'd0:    return op_sample_preload;
         8'd1:    return op_extest;
         8'd2:    return op_extest_toggle;
         8'd3:    return op_highz;
         8'd4:    return op_clamp;
         default: return bscan_opcode_e'(8'hFF);
      endcase
   endfunction

   // ********************************************************
   // reference model, falling edge
   // ********************************************************
   always @(negedge atappris_tck)
   begin
      if (!powergoodrst_trst_b)
      begin
         early_q   = 4'b0000;
         tog_q     = 1'b0;
         upd_clk_q = 1'b0;
         tdo_q     = 1'b0;
      end
      else
      begin
         cur_cls = op_class(ireg_drv);
         // shift stage only counts during update-ir
         shf_cls   = tap_drv.update_ir ? op_class(ir_shift_drv) : 5'b00000;
         early_q   = cur_cls[4:1] | shf_cls[4:1];
         tog_q     = tap_drv.tlrs ? 1'b0 : (~tog_q & cur_cls[1] & tap_drv.rti);
         upd_clk_q = tap_drv.update_dr & cur_cls[0];
         tdo_q     = tap_drv.tlrs ? 1'b0 : bscan_tdo_drv;
      end
   end

   task automatic report_value(input string name, input logic [7:0] exp, input logic [7:0] got);
      $display("[FAIL] t=%0t %s expected=%h actual=%h", $time, name, exp, got);
      test_errs++;
   endtask

   task automatic report_text(input string msg);
      $display("[ERROR] t=%0t %s", $time, msg);
      test_errs++;
   endtask

   // expected outputs from the current inputs and the model flops of the last fall
   task automatic check_outputs(input bit at_rise);
      logic [4:0] cls;
      bscan_pin_t exp_pin;
      bscan_dr_t  exp_dr;
      logic       exp_tdo;
      cls     = op_class(ireg_drv);
      exp_pin = {cls[4:1] & early_q, ~tog_q};
      exp_dr  = {tap_drv.capture_dr & cls[0], tap_drv.shift_dr & cls[0],
                 tap_drv.update_dr & cls[0], upd_clk_q};
      exp_tdo = (cls[0] & ~tap_drv.shift_ir_neg) ? tdo_q : pre_tdo_drv;
      if (o_pin !== exp_pin)
         report_value("o_pin", 8'(exp_pin), 8'(o_pin));
      if (o_dr !== exp_dr)
         report_value("o_dr", 8'(exp_dr), 8'(o_dr));
      if (o_tdo !== exp_tdo)
         report_value("o_tdo", 8'(exp_tdo), 8'(o_tdo));
      // tlrs held over the last fall clears both flops
      if (at_rise && tap_drv.tlrs && !o_pin.extogsig_b)
         report_text("toggle waveform not cleared by tlrs");
      if (at_rise && tap_drv.tlrs && cls[0] && !tap_drv.shift_ir_neg && o_tdo)
         report_text("retimed tdo not cleared by tlrs");
   endtask

   // check at the rise and drive the next inputs
   // kind 0 random, 1 toggle bias, 2 frequent tlrs, 3 idle
   task automatic step(input int kind);
      logic [31:0] rnd;
      tap_state_t  flags;
      @(posedge atappris_tck);
      check_outputs(1'b1);
      if (kind != 3)
      begin
         rnd   = $urandom();
         flags = rnd[6:0];
         if (kind != 2)
            flags.tlrs = &rnd[19:16];
         if (kind == 1)
            flags.rti = |rnd[15:13];
         if (hold_cnt == 0)
         begin
            ireg_drv <= (kind == 1 && rnd[21:20] != 2'b00) ? op_extest_toggle
                                                           : random_op(rnd[31:24]);
            hold_cnt = 2 + int'(rnd[12:10]) % 5;
         end
         hold_cnt = hold_cnt - 1;
         tap_drv       <= flags;
         ir_shift_drv  <= random_op(8'($urandom()));
         bscan_tdo_drv <= rnd[7];
         pre_tdo_drv   <= rnd[8];
         // before the next fall a new instruction is only armed by the early flops
         #2;
         check_outputs(1'b0);
      end
   endtask

   task automatic run_test(input string name, input int kind, input int cycles);
      test_errs = 0;
      repeat (cycles)
         step(kind);
      if (test_errs == 0)
         pass_cnt++;
      err_cnt += test_errs;
      $display("test %s: %0d cycles, %0d errors", name, cycles, test_errs);
   endtask

   // ********************************************************
   // test sequence
   // ********************************************************
   initial
   begin
      void'($urandom(34546));
      tap_drv       = '0;
      ireg_drv      = bscan_opcode_e'(8'h00);
      ir_shift_drv  = bscan_opcode_e'(8'h00);
      bscan_tdo_drv = 1'b0;
      pre_tdo_drv   = 1'b0;
      hold_cnt      = 0;
      err_cnt       = 0;
      pass_cnt      = 0;
      // first fall puts dut and model in reset together
      @(negedge atappris_tck);
      run_test("reset", 3, 4);
      run_test("random_a", 0, TEST_CYCLES);
      run_test("random_b", 0, TEST_CYCLES);
      run_test("random_c", 0, TEST_CYCLES);
      run_test("random_d", 0, TEST_CYCLES);
      run_test("extest_toggle", 1, TEST_CYCLES);
      run_test("tlrs", 2, TEST_CYCLES);
      $display("tests=%0d passed=%0d errors=%0d", NUM_TESTS, pass_cnt, err_cnt);
      if (err_cnt == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

   // watchdog allows 200 tck periods per test
   initial
   begin
      #(NUM_TESTS * 200 * 8);
      $display("timeout: the test sequence did not finish in time");
      $display(">>> FAIL");
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+include
hw/bscan_pkg.sv
hw/bscan_instr_decode.sv
hw/bscan_pin_ctrl.sv
hw/bscan_dr_ctrl.sv
hw/bscan_tdo_select.sv
hw/bscan_top.sv
tests/bscan_tb_clock.sv
tests/bscan_properties.sv
tests/bscan_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
TOP       ?= bscan_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := >>> PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
